//--- design/eth_pkg.sv
package eth_pkg;

   // host register bus
   localparam int eth_addr_w = 12;

   // frame buffers, 2048 bytes each
   localparam int buf_addr_w = 11;
   localparam int nbytes_w = 11;

   // locally administered address used until software writes rmac
   localparam logic [47:0] eth_rmac_default = 48'h02_1a_3c_4d_5e_6f;

   localparam int phy_rst_cycles = 64;

   // MII framing
   localparam int preamble_nibbles = 15;
   localparam logic [3:0] preamble_nibble = 4'h5;
   localparam logic [3:0] sfd_nibble = 4'hd;

   // register offsets, bit 11 set selects the data window instead
   typedef enum logic [eth_addr_w-1:0] {
      reg_status    = 12'd0,
      reg_control   = 12'd1,
      reg_rmac_lo   = 12'd2,
      reg_rmac_hi   = 12'd3,
      reg_scratch   = 12'd4,
      reg_tx_nbytes = 12'd5,
      reg_rx_nbytes = 12'd6
   } eth_reg_e;

   typedef struct packed {
      logic                  sel;
      logic                  we;
      logic [eth_addr_w-1:0] addr;
      logic [31:0]           wdata;
   } bus_req_t;

   typedef struct packed {
      logic                  we;
      logic [buf_addr_w-1:0] addr;
      logic [7:0]            data;
   } buf_wr_t;

   typedef struct packed {
      logic       en;
      logic [3:0] data;
   } mii_tx_t;

   typedef struct packed {
      logic       dv;
      logic [3:0] data;
   } mii_rx_t;

   typedef enum logic [2:0] {
      tx_idle, tx_preamble, tx_sfd, tx_low_nibble, tx_high_nibble
   } tx_state_e;

   typedef enum logic [2:0] {
      rx_idle, rx_armed, rx_address, rx_payload, rx_drop
   } rx_state_e;

endpackage

//--- design/eth_buffer.sv
`timescale 1ns/100ps

// simple dual-port frame store, one byte wide
module eth_buffer (
   input  logic                           clk,
   input  eth_pkg::buf_wr_t               wr,
   input  logic [eth_pkg::buf_addr_w-1:0] rd_addr,
   output logic [7:0]                     rd_data
);
   import eth_pkg::*;

   logic [7:0] mem [0:2**buf_addr_w-1];

   // write port
   always_ff @(posedge clk) begin
      if (wr.we) begin
         mem[wr.addr] <= wr.data;
      end
   end

   // registered read, one cycle of latency
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

//--- design/eth_regs.sv
`timescale 1ns/100ps

module eth_regs (
   input  logic                          clk,
   input  logic                          rst,
   input  eth_pkg::bus_req_t             req,
   output logic [31:0]                   rdata,
   input  logic [7:0]                    rx_rd_data,
   output logic [eth_pkg::buf_addr_w-1:0] rx_rd_addr,
   output eth_pkg::buf_wr_t              tx_wr,
   output logic                          send,
   output logic                          receive,
   output logic [eth_pkg::nbytes_w-1:0]  tx_nbytes,
   output logic [eth_pkg::nbytes_w-1:0]  rx_nbytes,
   output logic [47:0]                   rmac_addr,
   input  logic                          tx_ready_int,
   input  logic                          rx_ready_int,
   output logic                          phy_resetn
);
   import eth_pkg::*;

   eth_reg_e                          reg_addr;
   logic                              win_sel;
   logic                              reg_wr;
   logic                              reg_rd;
   logic                              win_rd;
   logic [31:0]                       scratch;
   logic [31:0]                       reg_rdata;
   logic [31:0]                       rdata_q;
   logic                              rd_win;
   logic [buf_addr_w-1:0]             rd_addr_q;
   logic                              tx_ready;
   logic                              rx_ready;
   logic [$clog2(phy_rst_cycles)-1:0] phy_cnt;

   // decode
   assign reg_addr = eth_reg_e'(req.addr);
   assign win_sel = req.addr[eth_addr_w-1];
   assign reg_wr = req.sel & req.we & ~win_sel;
   assign reg_rd = req.sel & ~req.we & ~win_sel;
   assign win_rd = req.sel & ~req.we & win_sel;

   // control pulses last exactly the write cycle
   assign send = reg_wr & (reg_addr == reg_control) & req.wdata[0];
   assign receive = reg_wr & (reg_addr == reg_control) & req.wdata[1];

   // host writes into the tx buffer through the data window
   assign tx_wr = '{we: req.sel & req.we & win_sel,
                    addr: req.addr[buf_addr_w-1:0],
                    data: req.wdata[7:0]};

   // ready bits are hidden while the phy is in reset
   assign tx_ready = tx_ready_int & phy_resetn;
   assign rx_ready = rx_ready_int & phy_resetn;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rmac_addr <= eth_rmac_default;
         scratch <= '0;
         tx_nbytes <= '0;
         rx_nbytes <= '0;
      end else if (reg_wr) begin
         case (reg_addr)
            reg_rmac_lo:   rmac_addr[23:0] <= req.wdata[23:0];
            reg_rmac_hi:   rmac_addr[47:24] <= req.wdata[23:0];
            reg_scratch:   scratch <= req.wdata;
            reg_tx_nbytes: tx_nbytes <= req.wdata[nbytes_w-1:0];
            reg_rx_nbytes: rx_nbytes <= req.wdata[nbytes_w-1:0];
            default: ;
         endcase
      end
   end

   always_comb begin
      case (reg_addr)
         reg_status:    reg_rdata = {30'b0, rx_ready, tx_ready};
         reg_rmac_lo:   reg_rdata = {8'b0, rmac_addr[23:0]};
         reg_rmac_hi:   reg_rdata = {8'b0, rmac_addr[47:24]};
         reg_scratch:   reg_rdata = scratch;
         reg_tx_nbytes: reg_rdata = 32'(tx_nbytes);
         reg_rx_nbytes: reg_rdata = 32'(rx_nbytes);
         default:       reg_rdata = '0;
      endcase
   end

   // buffer address is held so the window byte stays until the next read
   assign rx_rd_addr = win_rd ? req.addr[buf_addr_w-1:0] : rd_addr_q;

   always_ff @(posedge clk) begin
      if (reg_rd) begin
         rdata_q <= reg_rdata;
      end
      if (win_rd) begin
         rd_addr_q <= req.addr[buf_addr_w-1:0];
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_win <= 1'b0;
      end else if (reg_rd | win_rd) begin
         rd_win <= win_rd;
      end
   end

   assign rdata = rd_win ? {24'b0, rx_rd_data} : rdata_q;

   // phy reset hold
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         phy_cnt <= '0;
         phy_resetn <= 1'b0;
      end else if (phy_cnt != phy_rst_cycles - 1) begin
         phy_cnt <= phy_cnt + 1'b1;
      end else begin
         phy_resetn <= 1'b1;
      end
   end

   a_no_pulse_on_window_write: assert property (
      @(posedge clk) disable iff (rst) tx_wr.we |-> !(send || receive));

endmodule

//--- design/eth_tx.sv
`timescale 1ns/100ps

module eth_tx (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           send,
   input  logic [eth_pkg::nbytes_w-1:0]   nbytes,
   output logic                           ready,
   output logic [eth_pkg::buf_addr_w-1:0] rd_addr,
   input  logic [7:0]                     rd_data,
   output eth_pkg::mii_tx_t               mii_tx
);
   import eth_pkg::*;

   tx_state_e  state;
   logic [3:0] nib_cnt;
   logic [3:0] high_nib;

   // mii_tx is registered, so it trails the state by one cycle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= tx_idle;
         ready <= 1'b1;
         nib_cnt <= '0;
         rd_addr <= '0;
         mii_tx <= '0;
      end else begin
         mii_tx <= '0;
         case (state)
            tx_idle: begin
               ready <= 1'b1;
               if (send) begin
                  state <= tx_preamble;
                  ready <= 1'b0;
                  nib_cnt <= '0;
                  rd_addr <= '0;
               end
            end
            tx_preamble: begin
               mii_tx <= '{en: 1'b1, data: preamble_nibble};
               nib_cnt <= nib_cnt + 1'b1;
               if (nib_cnt == 4'(preamble_nibbles - 1)) begin
                  state <= tx_sfd;
               end
            end
            tx_sfd: begin
               mii_tx <= '{en: 1'b1, data: sfd_nibble};
               state <= (nbytes == '0) ? tx_idle : tx_low_nibble;
            end
            tx_low_nibble: begin
               mii_tx <= '{en: 1'b1, data: rd_data[3:0]};
               // fetch the next byte while the high nibble goes out
               rd_addr <= rd_addr + 1'b1;
               state <= tx_high_nibble;
            end
            tx_high_nibble: begin
               mii_tx <= '{en: 1'b1, data: high_nib};
               state <= (rd_addr == nbytes) ? tx_idle : tx_low_nibble;
            end
            default: state <= tx_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == tx_low_nibble) begin
         high_nib <= rd_data[7:4];
      end
   end

   a_ready_not_during_frame: assert property (
      @(posedge clk) disable iff (rst) !(mii_tx.en && ready));

endmodule

//--- design/eth_rx.sv
`timescale 1ns/100ps

module eth_rx (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         receive,
   input  logic [eth_pkg::nbytes_w-1:0] nbytes,
   input  logic [47:0]                  rmac_addr,
   input  eth_pkg::mii_rx_t             mii_rx,
   output logic                         ready,
   output eth_pkg::buf_wr_t             wr
);
   import eth_pkg::*;

   rx_state_e           state;
   logic [nbytes_w-1:0] byte_cnt;
   logic                half;
   logic [3:0]          low_nib;
   logic                uc_match;
   logic                bc_match;
   logic [7:0]          rx_byte;
   logic [7:0]          mac_byte;
   logic                uc_next;
   logic                bc_next;
   logic                last_byte;

   // destination compare, msb of the mac first
   always_comb begin
      rx_byte = {mii_rx.data, low_nib};
      mac_byte = rmac_addr[8*(3'd5 - byte_cnt[2:0]) +: 8];
      uc_next = uc_match && (rx_byte == mac_byte);
      bc_next = bc_match && (rx_byte == 8'hff);
      last_byte = (byte_cnt == nbytes - 1'b1);
   end

   always_ff @(posedge clk) begin
      if (mii_rx.dv && !half) begin
         low_nib <= mii_rx.data;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= rx_idle;
         ready <= 1'b1;
         byte_cnt <= '0;
         half <= 1'b0;
         uc_match <= 1'b0;
         bc_match <= 1'b0;
         wr <= '0;
      end else begin
         wr.we <= 1'b0;
         if (receive) begin
            state <= rx_armed;
            ready <= 1'b0;
         end else begin
            // byte assembly is shared by address and payload
            if ((state == rx_address || state == rx_payload) && mii_rx.dv) begin
               half <= ~half;
               if (half) begin
                  wr <= '{we: 1'b1, addr: byte_cnt, data: rx_byte};
                  byte_cnt <= byte_cnt + 1'b1;
               end
            end
            case (state)
               rx_idle: begin
                  // last byte went out the cycle before
                  if (wr.we) begin
                     ready <= 1'b1;
                  end
               end
               rx_armed: begin
                  if (mii_rx.dv && mii_rx.data == sfd_nibble) begin
                     state <= rx_address;
                     byte_cnt <= '0;
                     half <= 1'b0;
                     uc_match <= 1'b1;
                     bc_match <= 1'b1;
                  end
               end
               rx_address: begin
                  if (!mii_rx.dv) begin
                     state <= rx_armed;
                  end else if (half) begin
                     uc_match <= uc_next;
                     bc_match <= bc_next;
                     if (!uc_next && !bc_next) begin
                        state <= rx_drop;
                     end else if (byte_cnt == 5) begin
                        state <= last_byte ? rx_idle : rx_payload;
                     end
                  end
               end
               rx_payload: begin
                  if (!mii_rx.dv) begin
                     state <= rx_armed;
                  end else if (half && last_byte) begin
                     state <= rx_idle;
                  end
               end
               rx_drop: begin
                  if (!mii_rx.dv) begin
                     state <= rx_armed;
                  end
               end
               default: state <= rx_idle;
            endcase
         end
      end
   end

   a_write_from_frame: assert property (
      @(posedge clk) disable iff (rst)
      wr.we |-> ($past(state) inside {rx_address, rx_payload}));

endmodule

//--- design/eth_core.sv
`timescale 1ns/100ps

module eth_core (
   input  logic              clk,
   input  logic              rst,
   input  eth_pkg::bus_req_t req,
   output logic [31:0]       rdata,
   output logic              phy_resetn,
   input  eth_pkg::mii_rx_t  mii_rx,
   output eth_pkg::mii_tx_t  mii_tx
);
   import eth_pkg::*;

   buf_wr_t               tx_wr;
   buf_wr_t               rx_wr;
   logic [buf_addr_w-1:0] tx_rd_addr;
   logic [buf_addr_w-1:0] rx_rd_addr;
   logic [7:0]            tx_rd_data;
   logic [7:0]            rx_rd_data;
   logic                  send;
   logic                  receive;
   logic [nbytes_w-1:0]   tx_nbytes;
   logic [nbytes_w-1:0]   rx_nbytes;
   logic [47:0]           rmac_addr;
   logic                  tx_ready_int;
   logic                  rx_ready_int;

   eth_regs i_regs (
      .clk          (clk),
      .rst          (rst),
      .req          (req),
      .rdata        (rdata),
      .rx_rd_data   (rx_rd_data),
      .rx_rd_addr   (rx_rd_addr),
      .tx_wr        (tx_wr),
      .send         (send),
      .receive      (receive),
      .tx_nbytes    (tx_nbytes),
      .rx_nbytes    (rx_nbytes),
      .rmac_addr    (rmac_addr),
      .tx_ready_int (tx_ready_int),
      .rx_ready_int (rx_ready_int),
      .phy_resetn   (phy_resetn)
   );

   // written by the host, read by the transmitter
   eth_buffer tx_buffer (
      .clk     (clk),
      .wr      (tx_wr),
      .rd_addr (tx_rd_addr),
      .rd_data (tx_rd_data)
   );

   // written by the receiver, read by the host
   eth_buffer rx_buffer (
      .clk     (clk),
      .wr      (rx_wr),
      .rd_addr (rx_rd_addr),
      .rd_data (rx_rd_data)
   );

   eth_tx i_tx (
      .clk     (clk),
      .rst     (rst),
      .send    (send),
      .nbytes  (tx_nbytes),
      .ready   (tx_ready_int),
      .rd_addr (tx_rd_addr),
      .rd_data (tx_rd_data),
      .mii_tx  (mii_tx)
   );

   eth_rx i_rx (
      .clk       (clk),
      .rst       (rst),
      .receive   (receive),
      .nbytes    (rx_nbytes),
      .rmac_addr (rmac_addr),
      .mii_rx    (mii_rx),
      .ready     (rx_ready_int),
      .wr        (rx_wr)
   );

endmodule

//--- verification/eth_core_tb.sv
`timescale 1ns/100ps

module eth_core_tb;
   import eth_pkg::*;

   logic        clk;
   logic        rst;
   bus_req_t    req;
   logic [31:0] rdata;
   logic        phy_resetn;
   mii_rx_t     mii_rx;
   mii_tx_t     mii_tx;

   logic [31:0] lfsr;
   logic [7:0]  tx_bytes [0:127];
   logic [7:0]  rx_frame [0:127];
   int          tx_len;
   int          rx_len_uc;
   int          rx_len_bad;
   int          rx_len_bc;
   int          wd_cycles = 0;
   int          tx_nib_cnt = 0;
   int          tx_frames = 0;
   logic        tx_en_q = 1'b0;
   mii_tx_t     exp_nib;
   logic [47:0] new_mac;
   logic [31:0] st;
   logic [31:0] val;

   eth_core i_dut (
      .clk        (clk),
      .rst        (rst),
      .req        (req),
      .rdata      (rdata),
      .phy_resetn (phy_resetn),
      .mii_rx     (mii_rx),
      .mii_tx     (mii_tx)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_rdata(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         report_failure($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_nibble(input mii_tx_t got, input mii_tx_t exp);
      if (got !== exp) begin
         report_failure($sformatf("Error: mii_tx is 0x%h, expected 0x%h", got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         report_failure($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // 15 preamble nibbles, sfd, then payload low nibble first
   function automatic logic [3:0] expected_tx_nibble(input int idx);
      int k;
      k = idx - 16;
      if (idx < 15) begin
         return 4'h5;
      end else if (idx == 15) begin
         return 4'hd;
      end else if (k % 2 == 0) begin
         return tx_bytes[k / 2][3:0];
      end else begin
         return tx_bytes[k / 2][7:4];
      end
   endfunction

   function automatic bit expect_accept(input logic [47:0] dest, input logic [47:0] mac);
      return (dest == mac) || (dest == 48'hffff_ffff_ffff);
   endfunction

   task automatic bus_write(input logic [11:0] addr, input logic [31:0] data);
      @(negedge clk);
      req = '{sel: 1'b1, we: 1'b1, addr: addr, wdata: data};
      @(negedge clk);
      req = '0;
   endtask

   task automatic bus_read(input logic [11:0] addr, output logic [31:0] data);
      @(negedge clk);
      req = '{sel: 1'b1, we: 1'b0, addr: addr, wdata: 32'h0};
      @(negedge clk);
      data = rdata;
      req = '0;
   endtask

   task automatic poll_status(input int idx);
      logic [31:0] s;
      s = '0;
      while (s[idx] !== 1'b1) begin
         bus_read(reg_status, s);
      end
   endtask

   task automatic build_rx_frame(input logic [47:0] dest, input int n);
      for (int i = 0; i < 6; i++) begin
         rx_frame[i] = dest[47 - 8 * i -: 8];
      end
      for (int i = 6; i < n; i++) begin
         rx_frame[i] = 8'(rand_bits(8));
      end
   endtask

   task automatic send_mii_frame(input int n);
      for (int i = 0; i < 15; i++) begin
         @(negedge clk);
         mii_rx = '{dv: 1'b1, data: 4'h5};
      end
      @(negedge clk);
      mii_rx = '{dv: 1'b1, data: 4'hd};
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
         mii_rx = '{dv: 1'b1, data: rx_frame[i][3:0]};
         @(negedge clk);
         mii_rx = '{dv: 1'b1, data: rx_frame[i][7:4]};
      end
      // gap so the receiver sees dv low
      @(negedge clk);
      mii_rx = '0;
      repeat (4) @(negedge clk);
   endtask

   task automatic receive_and_filter(input logic [47:0] dest, input logic [47:0] mac,
                                     input int n);
      logic [31:0] s;
      build_rx_frame(dest, n);
      send_mii_frame(n);
      if (expect_accept(dest, mac)) begin
         poll_status(1);
      end else begin
         bus_read(reg_status, s);
         check_flag("rx_ready", s[1], 1'b0);
      end
   endtask

   task automatic read_rx_frame(input int n);
      logic [31:0] v;
      for (int i = 0; i < n; i++) begin
         bus_read({1'b1, 11'(i)}, v);
         check_rdata($sformatf("rx byte %0d", i), v, {24'h0, rx_frame[i]});
      end
   endtask

   task automatic run_tx_frame(input bit resend);
      logic [31:0] s;
      tx_nib_cnt = 0;
      tx_frames = 0;
      bus_write(reg_control, 32'h1);
      bus_read(reg_status, s);
      check_flag("tx_ready", s[0], 1'b0);
      if (resend) begin
         bus_write(reg_control, 32'h1);
      end
      poll_status(0);
      repeat (8) @(negedge clk);
      if (tx_nib_cnt != 16 + 2 * tx_len) begin
         report_failure("the TX frame did not have the expected number of nibbles");
      end
      if (tx_frames != 1) begin
         report_failure("more than one TX frame went out for one send");
      end
   endtask

   // compares every transmitted nibble against the reference stream
   always @(negedge clk) begin
      if (!rst && mii_tx.en) begin
         if (!tx_en_q) begin
            tx_frames++;
         end
         if (tx_nib_cnt >= 16 + 2 * tx_len) begin
            report_failure("the TX frame ran past its programmed length");
         end
         exp_nib.en = 1'b1;
         exp_nib.data = expected_tx_nibble(tx_nib_cnt);
         check_nibble(mii_tx, exp_nib);
         tx_nib_cnt++;
      end
      tx_en_q = mii_tx.en;
   end

   initial begin
      wait (wd_cycles > 0);
      repeat (wd_cycles) @(posedge clk);
      report_failure("timeout, the DUT stopped making progress");
   end

   initial begin
      rst = 1'b1;
      req = '0;
      mii_rx = '0;
      lfsr = 32'h402;
      tx_len = 16 + int'(rand_bits(6));
      rx_len_uc = 20 + int'(rand_bits(5));
      rx_len_bad = 20 + int'(rand_bits(5));
      rx_len_bc = 20 + int'(rand_bits(5));
      wd_cycles = 4 * (2 * tx_len + rx_len_uc + rx_len_bad + rx_len_bc) + 2000;
      repeat (10) @(negedge clk);
      rst = 1'b0;

      // phy reset hold, status masked until it ends
      bus_read(reg_status, st);
      check_rdata("status", st, 32'h0);
      for (int c = 3; c <= 63; c++) begin
         @(negedge clk);
         check_flag("phy_resetn", phy_resetn, 1'b0);
      end
      @(negedge clk);
      check_flag("phy_resetn", phy_resetn, 1'b1);
      bus_read(reg_status, st);
      check_rdata("status", st, 32'h3);

      val = rand_bits(32);
      bus_write(reg_scratch, val);
      bus_read(reg_scratch, st);
      check_rdata("scratch", st, val);

      // transmit a random frame
      for (int i = 0; i < tx_len; i++) begin
         tx_bytes[i] = 8'(rand_bits(8));
         bus_write({1'b1, 11'(i)}, 32'(tx_bytes[i]));
      end
      bus_write(reg_tx_nbytes, 32'(tx_len));
      bus_read(reg_tx_nbytes, st);
      check_rdata("tx_nbytes", st, 32'(tx_len));
      run_tx_frame(1'b0);

      // unicast to the reset mac address
      bus_write(reg_rx_nbytes, 32'(rx_len_uc));
      bus_read(reg_rx_nbytes, st);
      check_rdata("rx_nbytes", st, 32'(rx_len_uc));
      bus_write(reg_control, 32'h2);
      bus_read(reg_status, st);
      check_flag("rx_ready", st[1], 1'b0);
      receive_and_filter(eth_rmac_default, eth_rmac_default, rx_len_uc);
      read_rx_frame(rx_len_uc);

      // new mac, so the old address must be dropped
      val = rand_bits(24);
      new_mac[47:24] = val[23:0];
      val = rand_bits(24);
      new_mac[23:0] = val[23:0];
      bus_write(reg_rmac_lo, {8'h0, new_mac[23:0]});
      bus_write(reg_rmac_hi, {8'h0, new_mac[47:24]});
      bus_read(reg_rmac_lo, st);
      check_rdata("rmac_lo", st, {8'h0, new_mac[23:0]});
      bus_read(reg_rmac_hi, st);
      check_rdata("rmac_hi", st, {8'h0, new_mac[47:24]});
      bus_write(reg_rx_nbytes, 32'(rx_len_bc));
      bus_write(reg_control, 32'h2);
      receive_and_filter(eth_rmac_default, new_mac, rx_len_bad);
      receive_and_filter(48'hffff_ffff_ffff, new_mac, rx_len_bc);
      read_rx_frame(rx_len_bc);

      // second send while the frame is still going out
      run_tx_frame(1'b1);

      $display("Everything OK");
      $finish;
   end

endmodule

//--- eth_core.f
design/eth_pkg.sv
design/eth_buffer.sv
design/eth_regs.sv
design/eth_tx.sv
design/eth_rx.sv
design/eth_core.sv
verification/eth_core_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = eth_core_tb
FILELIST = eth_core.f
OBJ_DIR  = obj_dir
PASS_MSG = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
